// ==== hw/shifterPkg.sv ====
`default_nettype none

package shifterPkg;

  // Shift type field of a register operand
  localparam logic [1:0] shLsl = 2'b00;
  localparam logic [1:0] shLsr = 2'b01;
  localparam logic [1:0] shAsr = 2'b10;
  localparam logic [1:0] shRor = 2'b11; // RRX when encoded amount is 0

  // Operand 2 field, read as immediate or as shifted register
  typedef union packed {
    struct packed {
      logic [3:0] rot;        // Rotate right by twice this
      logic [7:0] value;
    } imm;
    struct packed {
      logic [4:0] amount;     // Immediate amount, or Rs index plus zero bit
      logic [1:0] shType;
      logic       regShift;   // Amount comes from Rs
      logic [3:0] rm;
    } sreg;
  } operand2T;

  // Request presented with inValid
  typedef struct packed {
    operand2T    op2;
    logic        isImm;       // Immediate form of operand 2
    logic [31:0] rmValue;
    logic [31:0] rsValue;     // Only low byte used
    logic        prevCarry;   // Current C flag
    logic        multCsel;    // Take RRX carry from multiplier
    logic        multCarry;
  } shiftReqT;

  // Registered result
  typedef struct packed {
    logic [31:0] value;
    logic        carry;
  } shiftResT;

  // Decoded operand 2, feeds shift control
  typedef struct packed {
    logic [1:0]  shType;
    logic [4:0]  rShamt;      // Encoded immediate amount
    logic [7:0]  rsrShamt;    // Low byte of Rs
    logic        isRtype;     // Shift by immediate amount
    logic        isRsrType;   // Shift by register amount
    logic        zeroRotate;  // Immediate with rotate field 0
    logic [31:0] operand;     // Value entering the shifter
  } shiftCtlT;

endpackage

`default_nettype wire

// ==== hw/operandDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module operandDecode import shifterPkg::*; (
  input  shiftReqT req,
  output shiftCtlT ctl
);

  logic [4:0]  immRot;    // Twice the rotate field
  logic [63:0] immPair;   // Byte placed twice so a right shift rotates
  logic [63:0] immShift;
  logic [31:0] immValue;

  // Rotate right by 2 * rot
  assign immRot   = {req.op2.imm.rot, 1'b0};
  assign immPair  = {2{24'h000000, req.op2.imm.value}};
  assign immShift = immPair >> immRot;
  assign immValue = immShift[31:0];

  always_comb begin
    if (req.isImm) begin
      // Immediate bypasses the shifter
      ctl.shType     = shLsl;
      ctl.rShamt     = 5'd0;
      ctl.isRtype    = 1'b0;
      ctl.isRsrType  = 1'b0;
      ctl.zeroRotate = (req.op2.imm.rot == 4'd0); // Carry stays C
      ctl.operand    = immValue;
    end else begin
      ctl.shType     = req.op2.sreg.shType;
      ctl.rShamt     = req.op2.sreg.amount;
      ctl.isRtype    = ~req.op2.sreg.regShift;
      ctl.isRsrType  = req.op2.sreg.regShift;
      ctl.zeroRotate = 1'b0;
      ctl.operand    = req.rmValue;
    end
    ctl.rsrShamt = req.rsValue[7:0]; // Ignored unless RSR
  end

  // Bit 7 is zero in every RSR encoding, else it's another instruction class
  always_comb begin
    if (!req.isImm && req.op2.sreg.regShift) begin
      assert final (req.op2.sreg.amount[0] == 1'b0)
        else $error("RSR operand with bit 7 set");
    end
  end

endmodule

`default_nettype wire

// ==== hw/shiftControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module shiftControl import shifterPkg::*; (
  input  shiftCtlT   ctl,
  input  logic       prevCarry,
  input  logic       multCsel,
  input  logic       multCarry,
  input  logic       rot0,       // Unmasked rotator bit 0
  input  logic       rot31,      // Unmasked rotator bit 31
  output logic [4:0] shamt,
  output logic       left,
  output logic       arith,
  output logic       longShift,
  output logic       rrx,
  output logic       rrxIn,
  output logic       isShift,    // Masking shift, not a rotate
  output logic       carryOut
);

  logic       shiftSel;          // Register or RSR form
  logic [4:0] rAmt;
  logic [6:0] actualShift;       // 0 to 127 after saturation
  logic       shift0;
  logic       shift32;
  logic       shift33;           // 33 and above
  logic       a0;
  logic       a31;

  assign a0  = ctl.operand[0];
  assign a31 = ctl.operand[31];

  assign shiftSel = ctl.isRtype | ctl.isRsrType;

  // ROR #0 in the register form is RRX, a rotate by one
  assign rrx  = ctl.isRtype & (ctl.shType == shRor) & (ctl.rShamt == 5'd0);
  assign rAmt = rrx ? 5'd1 : ctl.rShamt;

  // Real amount; LSR and ASR #0 mean 32, LSL #0 stays 0
  always_comb begin
    if (!shiftSel)
      actualShift = 7'd0;
    else if (ctl.isRsrType)
      actualShift = {|ctl.rsrShamt[7:6], ctl.rsrShamt[5:0]}; // Saturate above 64
    else
      actualShift = {1'b0, (ctl.shType != shLsl) && (rAmt == 5'd0), rAmt};
  end

  // ROR of 32 and more wraps modulo 32, so no mask there
  assign longShift = (|actualShift[6:5]) & (ctl.shType != shRor);
  assign shamt     = actualShift[4:0];

  assign shift0  = (actualShift == 7'd0);
  assign shift32 = (actualShift == 7'd32);
  assign shift33 = (actualShift > 7'd32);

  always_comb begin
    case (ctl.shType)
      shLsl:   {isShift, left, arith} = 3'b110;
      shLsr:   {isShift, left, arith} = 3'b100;
      shAsr:   {isShift, left, arith} = 3'b101;
      default: {isShift, left, arith} = 3'b000; // ROR and RRX
    endcase
  end

  assign rrxIn = multCsel ? multCarry : prevCarry; // Bit entering at 31

  // Carry by form, amount class and type
  always_comb begin
    casez ({shiftSel, ctl.isRsrType, shift33, shift32, shift0, ctl.shType})
      // Immediate, C kept when not rotated
      7'b0_?_???_?? : carryOut = ctl.zeroRotate ? prevCarry : a31;
      // Amount 0, any form
      7'b1_?_001_?? : carryOut = prevCarry;
      // 1 to 31
      7'b1_?_000_00 : carryOut = rot0;  // LSL, last bit out on the left
      7'b1_?_000_?? : carryOut = rot31; // LSR ASR ROR, RRX gives a0 here
      // Register form, LSR or ASR #0
      7'b1_0_010_?? : carryOut = a31;
      // RSR by exactly 32
      7'b1_1_010_00 : carryOut = a0;
      7'b1_1_010_?? : carryOut = a31;
      // RSR by 33 and more
      7'b1_1_100_00,
      7'b1_1_100_01 : carryOut = 1'b0;  // Everything shifted out
      7'b1_1_100_10 : carryOut = a31;   // Sign
      7'b1_1_100_11 : carryOut = rot31; // Modulo 32 rotate
      default       : carryOut = prevCarry;
    endcase
  end

  // Decoder never flags both register forms
  always_comb begin
    if (ctl.isRtype) begin
      assert final (!ctl.isRsrType)
        else $error("Register and RSR forms both set");
    end
  end

endmodule

`default_nettype wire

// ==== hw/shiftDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module shiftDecoder (
  input  logic [4:0]  shamt,
  input  logic        left,
  output logic [4:0]  rotAmt,
  output logic [31:0] keepMask
);

  logic [4:0]  negAmt;     // 32 - shamt, modulo 32
  logic [31:0] rightMask;  // Top shamt bits cleared
  logic [31:0] leftMask;   // Low shamt bits cleared

  // Left by n is right rotate by 32 - n
  assign negAmt = 5'd0 - shamt;
  assign rotAmt = left ? negAmt : shamt;

  // Zero amount keeps every bit
  assign rightMask = 32'hFFFF_FFFF >> shamt;
  assign leftMask  = 32'hFFFF_FFFF << shamt;

  assign keepMask = left ? leftMask : rightMask;

endmodule

`default_nettype wire

// ==== hw/barrelShifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module barrelShifter (
  input  logic [31:0] operand,
  input  logic [4:0]  rotAmt,     // Right rotate amount
  input  logic [31:0] keepMask,
  input  logic        isShift,    // Apply mask, off for ROR
  input  logic        arith,      // Fill cleared bits with sign
  input  logic        longShift,  // 32 and more, nothing survives
  input  logic        rrxIn,
  input  logic        rrx,
  output logic [31:0] shifted,
  output logic        rot0,
  output logic        rot31
);

  logic [5:0][31:0] stage;        // Log rotator, stage 0 is the input
  logic [31:0]      fill;
  logic [31:0]      masked;
  logic [31:0]      filled;

  assign stage[0] = operand;

  // Stage i rotates right by 2**i
  for (genvar i = 0; i < 5; i++) begin : rotStage
    assign stage[i+1] = rotAmt[i] ? {stage[i][(1 << i) - 1:0], stage[i][31:(1 << i)]}
                                  : stage[i];
  end

  // Edge bits for carry, before any masking
  assign rot0  = stage[5][0];
  assign rot31 = stage[5][31];

  assign fill = {32{arith & operand[31]}};

  always_comb begin
    if (isShift)
      masked = (stage[5] & keepMask) | (fill & ~keepMask);
    else
      masked = stage[5];
  end

  assign filled  = longShift ? fill : masked;
  assign shifted = rrx ? {rrxIn, filled[30:0]} : filled; // C into bit 31

endmodule

`default_nettype wire

// ==== hw/shifterTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module shifterTop import shifterPkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     inValid,
  input  shiftReqT req,
  output logic     outValid,
  output shiftResT res
);

  shiftCtlT    ctl;
  logic [4:0]  shamt;
  logic [4:0]  rotAmt;
  logic [31:0] keepMask;
  logic [31:0] shifted;
  logic        left;
  logic        arith;
  logic        longShift;
  logic        rrx;
  logic        rrxIn;
  logic        isShift;
  logic        carryOut;
  logic        rot0;
  logic        rot31;
  logic        useShifter;  // Register forms only
  shiftResT    nextRes;

  operandDecode u_operandDecode (.req(req), .ctl(ctl));

  shiftControl u_shiftControl (
    .ctl(ctl), .prevCarry(req.prevCarry), .multCsel(req.multCsel),
    .multCarry(req.multCarry), .rot0(rot0), .rot31(rot31), .shamt(shamt),
    .left(left), .arith(arith), .longShift(longShift), .rrx(rrx), .rrxIn(rrxIn),
    .isShift(isShift), .carryOut(carryOut)
  );

  shiftDecoder u_shiftDecoder (.shamt(shamt), .left(left), .rotAmt(rotAmt), .keepMask(keepMask));

  barrelShifter u_barrelShifter (
    .operand(ctl.operand), .rotAmt(rotAmt), .keepMask(keepMask), .isShift(isShift),
    .arith(arith), .longShift(longShift), .rrxIn(rrxIn), .rrx(rrx),
    .shifted(shifted), .rot0(rot0), .rot31(rot31)
  );

  // Expanded immediate skips the rotator
  assign useShifter    = ctl.isRtype | ctl.isRsrType;
  assign nextRes.value = useShifter ? shifted : ctl.operand;
  assign nextRes.carry = carryOut;

  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= 1'b0;
      res      <= '0;
    end else begin
      outValid <= inValid;            // One cycle behind
      if (inValid)
        res <= nextRes;
    end
  end

  // Strobe carries a fully driven request
  assert property (@(posedge clk) disable iff (rst) inValid |-> !$isunknown(req))
    else $error("Request has unknown bits at a strobe");

  // Zero amount without long shift or RRX leaves the operand untouched
  assert property (@(posedge clk) disable iff (rst)
    inValid && useShifter && shamt == 5'd0 && !longShift && !rrx
    |-> shifted == ctl.operand)
    else $error("Operand changed by a zero amount shift");

endmodule

`default_nettype wire

// ==== testbench/shifterRef.svh ====
`ifndef SHIFTER_REF_SVH
`define SHIFTER_REF_SVH

`default_nettype none

// Rotate right, n in 0 to 31
function automatic logic [31:0] rorWord(input logic [31:0] x, input int n);
  return (x >> n) | (x << (32 - n)); // n of 0 leaves x
endfunction

// Shift by 1 to 31, carry is the last bit shifted out
function automatic shifterPkg::shiftResT shiftBy(input logic [31:0] a, input logic [1:0] t,
                                                 input int n);
  shifterPkg::shiftResT o;
  case (t)
    shifterPkg::shLsl: begin
      o.value = a << n;
      o.carry = a[32 - n];
    end
    shifterPkg::shLsr: begin
      o.value = a >> n;
      o.carry = a[n - 1];
    end
    shifterPkg::shAsr: begin
      o.value = $signed(a) >>> n;
      o.carry = a[n - 1];
    end
    default: begin
      o.value = rorWord(a, n);
      o.carry = a[n - 1];
    end
  endcase
  return o;
endfunction

// Expected value and carry of one request
function automatic shifterPkg::shiftResT refShift(input shifterPkg::shiftReqT r);
  shifterPkg::shiftResT o;
  logic [31:0] a;
  logic [1:0]  t;
  logic        cin;
  int          n;
  a       = r.rmValue;
  t       = r.op2.sreg.shType;
  cin     = r.multCsel ? r.multCarry : r.prevCarry; // RRX fill bit
  o.value = a;                                     // No shift by default
  o.carry = r.prevCarry;
  if (r.isImm) begin
    o.value = rorWord({24'd0, r.op2.imm.value}, 2 * r.op2.imm.rot);
    o.carry = (r.op2.imm.rot == 4'd0) ? r.prevCarry : o.value[31];
  end else if (!r.op2.sreg.regShift) begin
    n = r.op2.sreg.amount;
    if (n != 0)
      o = shiftBy(a, t, n);
    else if (t == shifterPkg::shLsr)
      o = '{value: 32'd0, carry: a[31]};        // LSR #32
    else if (t == shifterPkg::shAsr)
      o = '{value: {32{a[31]}}, carry: a[31]};  // ASR #32
    else if (t == shifterPkg::shRor)
      o = '{value: {cin, a[31:1]}, carry: a[0]}; // RRX
  end else begin
    n = r.rsValue[7:0];
    if (n != 0 && n < 32)
      o = shiftBy(a, t, n);
    else if (n >= 32) begin
      if (t == shifterPkg::shRor) begin
        if (n % 32 != 0)
          o = shiftBy(a, t, n % 32);
        else
          o.carry = a[31]; // Full turn, value unchanged
      end else if (t == shifterPkg::shAsr)
        o = '{value: {32{a[31]}}, carry: a[31]};
      else if (n == 32)
        o = '{value: 32'd0, carry: (t == shifterPkg::shLsl) ? a[0] : a[31]};
      else
        o = '{value: 32'd0, carry: 1'b0};
    end
  end
  return o;
endfunction

`default_nettype wire

`endif

// ==== testbench/shifterTb.sv ====
`timescale 1ns/1ps
`include "shifterRef.svh"
`default_nettype none

module shifterTb import shifterPkg::*; ();

  localparam logic [31:0] rmA = 32'h8000_00F1; // Both edge bits set

  logic     clk = 1'b0;
  logic     rst;
  logic     inValid;
  shiftReqT req;
  logic     outValid;
  shiftResT res;
  integer   seed = 32'hd95072a3;

  // Directed table
  shiftReqT tblReq[$];
  shiftResT tblExp[$];
  string    tblName[$];

  shifterTop u_shifterTop (
    .clk(clk), .rst(rst), .inValid(inValid), .req(req), .outValid(outValid), .res(res)
  );

  always #20 clk = ~clk; // 40 ns period

  task automatic stopWithError(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
      stopWithError($sformatf("mismatch %s value expected %h actual %h", name, exp, act));
  endtask

  task automatic checkCarry(input string name, input logic exp, input logic act);
    if (act !== exp)
      stopWithError($sformatf("mismatch %s carry expected %b actual %b", name, exp, act));
  endtask

  function automatic shiftReqT immReq(input logic [3:0] rot, input logic [7:0] val,
                                      input logic prev);
    shiftReqT r;
    r               = '0;
    r.isImm         = 1'b1;
    r.op2.imm.rot   = rot;
    r.op2.imm.value = val;
    r.prevCarry     = prev;
    return r;
  endfunction

  // RSR form uses Rs index 3 with the zero bit clear
  function automatic shiftReqT regReq(input logic rsr, input logic [4:0] amt,
                                      input logic [1:0] t, input logic [7:0] rs,
                                      input logic prev, input logic msel, input logic mc);
    shiftReqT r;
    r                    = '0;
    r.op2.sreg.amount    = rsr ? 5'b00110 : amt;
    r.op2.sreg.shType    = t;
    r.op2.sreg.regShift  = rsr;
    r.op2.sreg.rm        = 4'h2;
    r.rmValue            = rmA;
    r.rsValue            = {24'h5A5A5A, rs}; // Upper bytes must not matter
    r.prevCarry          = prev;
    r.multCsel           = msel;
    r.multCarry          = mc;
    return r;
  endfunction

  task automatic addVec(input string name, input shiftReqT r, input logic [31:0] value,
                        input logic carry);
    tblName.push_back(name);
    tblReq.push_back(r);
    tblExp.push_back('{value: value, carry: carry});
  endtask

  // Sample on the falling edge, result must follow one cycle after the strobe
  task automatic waitResult(input string name);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      inValid = 1'b0;
      cycles++;
    end while (!outValid && cycles < 4);
    if (!outValid)
      stopWithError($sformatf("%s: the output valid never arrived", name));
    if (cycles != 1)
      stopWithError($sformatf("%s: result came after %0d cycles, not one", name, cycles));
  endtask

  task automatic runCase(input string name, input shiftReqT r, input shiftResT exp);
    req     = r;
    inValid = 1'b1;
    waitResult(name);
    checkValue(name, exp.value, res.value);
    checkCarry(name, exp.carry, res.carry);
  endtask

  initial begin
    shiftReqT    r;
    logic [31:0] word;
    rst     = 1'b1;
    inValid = 1'b0;
    req     = '0;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    if (outValid !== 1'b0 || res !== '0)
      stopWithError("outputs were not cleared by reset");

    addVec("immRot0", immReq(4'd0, 8'hAB, 1'b1), 32'h0000_00AB, 1'b1);
    addVec("immRot1", immReq(4'd1, 8'h03, 1'b0), 32'hC000_0000, 1'b1);
    addVec("immRot15", immReq(4'd15, 8'h81, 1'b1), 32'h0000_0204, 1'b0);
    addVec("lsl1", regReq(0, 5'd1, shLsl, 8'd0, 0, 0, 0), 32'h0000_01E2, 1'b1);
    addVec("lsr4", regReq(0, 5'd4, shLsr, 8'd0, 1, 0, 0), 32'h0800_000F, 1'b0);
    addVec("asr5", regReq(0, 5'd5, shAsr, 8'd0, 0, 0, 0), 32'hFC00_0007, 1'b1);
    addVec("ror8", regReq(0, 5'd8, shRor, 8'd0, 0, 0, 0), 32'hF180_0000, 1'b1);
    addVec("lsl0", regReq(0, 5'd0, shLsl, 8'd0, 1, 0, 0), rmA, 1'b1);
    addVec("lsr0", regReq(0, 5'd0, shLsr, 8'd0, 0, 0, 0), 32'h0000_0000, 1'b1);
    addVec("asr0", regReq(0, 5'd0, shAsr, 8'd0, 0, 0, 0), 32'hFFFF_FFFF, 1'b1);
    addVec("rrxC", regReq(0, 5'd0, shRor, 8'd0, 0, 0, 1), 32'h4000_0078, 1'b1);
    addVec("rrxMul", regReq(0, 5'd0, shRor, 8'd0, 0, 1, 1), 32'hC000_0078, 1'b1);
    addVec("rsLsl0", regReq(1, 5'd0, shLsl, 8'd0, 0, 0, 0), rmA, 1'b0);
    addVec("rsLsr0", regReq(1, 5'd0, shLsr, 8'd0, 1, 0, 0), rmA, 1'b1);
    addVec("rsAsr0", regReq(1, 5'd0, shAsr, 8'd0, 0, 0, 0), rmA, 1'b0);
    addVec("rsRor0", regReq(1, 5'd0, shRor, 8'd0, 1, 0, 0), rmA, 1'b1);
    addVec("rsLsl32", regReq(1, 5'd0, shLsl, 8'd32, 0, 0, 0), 32'h0000_0000, 1'b1);
    addVec("rsLsr32", regReq(1, 5'd0, shLsr, 8'd32, 0, 0, 0), 32'h0000_0000, 1'b1);
    addVec("rsAsr32", regReq(1, 5'd0, shAsr, 8'd32, 0, 0, 0), 32'hFFFF_FFFF, 1'b1);
    addVec("rsRor32", regReq(1, 5'd0, shRor, 8'd32, 0, 0, 0), rmA, 1'b1);
    addVec("rsLsl33", regReq(1, 5'd0, shLsl, 8'd33, 1, 0, 0), 32'h0000_0000, 1'b0);
    addVec("rsLsr33", regReq(1, 5'd0, shLsr, 8'd33, 1, 0, 0), 32'h0000_0000, 1'b0);
    addVec("rsAsr33", regReq(1, 5'd0, shAsr, 8'd33, 0, 0, 0), 32'hFFFF_FFFF, 1'b1);
    addVec("rsRor33", regReq(1, 5'd0, shRor, 8'd33, 0, 0, 0), 32'hC000_0078, 1'b1);
    addVec("rsLsl255", regReq(1, 5'd0, shLsl, 8'd255, 1, 0, 0), 32'h0000_0000, 1'b0);
    addVec("rsLsr255", regReq(1, 5'd0, shLsr, 8'd255, 1, 0, 0), 32'h0000_0000, 1'b0);
    addVec("rsAsr255", regReq(1, 5'd0, shAsr, 8'd255, 0, 0, 0), 32'hFFFF_FFFF, 1'b1);
    addVec("rsRor255", regReq(1, 5'd0, shRor, 8'd255, 1, 0, 0), 32'h0000_01E3, 1'b0);

    // Back to back, one strobe per cycle
    for (int i = 0; i < tblReq.size(); i++)
      runCase(tblName[i], tblReq[i], tblExp[i]);
    @(negedge clk);
    if (outValid)
      stopWithError("outValid stayed high with no strobe");

    for (int i = 0; i < 200; i++) begin
      word        = $random(seed);
      r           = '0;
      r.op2       = word[11:0];
      r.isImm     = word[12];
      r.prevCarry = word[13];
      r.multCsel  = word[14];
      r.multCarry = word[15];
      r.rmValue   = $random(seed);
      r.rsValue   = $random(seed);
      if (word[16])
        r.rsValue[7:6] = 2'b00; // More amounts below 64
      if (!r.isImm && r.op2.sreg.regShift)
        r.op2.sreg.amount[0] = 1'b0;
      runCase($sformatf("rand%0d", i), r, refShift(r));
      if (word[17]) begin
        @(negedge clk); // Idle gap, pulse must drop
        if (outValid)
          stopWithError("outValid stayed high after an idle cycle");
      end
    end

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+testbench
hw/shifterPkg.sv
hw/operandDecode.sv
hw/shiftControl.sv
hw/shiftDecoder.sv
hw/barrelShifter.sv
hw/shifterTop.sv
testbench/shifterTb.sv
